// ==== Makefile ====
# Verilator build of the max-pooling engine testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_pool_engine
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= TEST OK
FAIL_MSG  ?= TEST FAILED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the result, the exit status of the binary is not used
run: compile
	-$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== project.f ====
source/engine_cfg_pkg.sv
source/layer_isa_pkg.sv
source/shared_sram.sv
source/layer_decoder.sv
source/max_pooler.sv
source/pool_engine_top.sv
test/pool_engine_props.sv
test/tb_pool_engine.sv

// ==== source/engine_cfg_pkg.sv ====
`default_nettype none

// widths and access types common to all memories
package engine_cfg_pkg;

	// pixel and address widths
	localparam int DATA_W = 16;
	localparam int ADDR_W = 10;

	// one unsigned feature value
	typedef logic [DATA_W-1:0] pixel_t;

	// word address, same for every memory
	typedef logic [ADDR_W-1:0] addr_t;

	// one access to a shared_sram
	// we low means read
	typedef struct packed {
		logic   en;
		logic   we;
		addr_t  addr;
		pixel_t wdata;
	} sram_req_t;

endpackage

`default_nettype wire

// ==== source/layer_decoder.sv ====
`default_nettype none

module layer_decoder (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        start,
	input  layer_isa_pkg::layer_instr_t instr,
	output engine_cfg_pkg::sram_req_t   prog_req,
	output layer_isa_pkg::pool_job_t    job,
	output logic                        launch,
	input  logic                        pool_done,
	output logic                        busy,
	output logic                        done
);

	typedef enum logic [1:0] {
		IDLE,
		FETCH,
		DECODE,
		WAIT_POOL
	} state_t;

	state_t                state;
	engine_cfg_pkg::addr_t pc;

	////////////////////
	// program fetch
	// read request only, instr back one cycle later
	always_comb begin
		prog_req      = '0;
		prog_req.en   = (state == FETCH);
		prog_req.addr = pc;
	end

	// busy covers fetch, decode and the pool run
	assign busy = (state != IDLE);

	////////////////////
	// control fsm
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= IDLE;
			pc     <= '0;
			launch <= 1'b0;
			done   <= 1'b0;
		end else begin
			// pulses by default
			launch <= 1'b0;
			done   <= 1'b0;
			case (state)
				IDLE: begin
					// program always starts at word 0
					if (start) begin
						pc    <= '0;
						state <= FETCH;
					end
				end
				FETCH: state <= DECODE;
				DECODE: begin
					if (instr.opcode == layer_isa_pkg::OP_POOL) begin
						launch <= 1'b1;
						pc     <= pc + engine_cfg_pkg::addr_t'(1);
						state  <= WAIT_POOL;
					end else begin
						// halt or unknown opcode
						done  <= 1'b1;
						state <= IDLE;
					end
				end
				// next descriptor once pooler is finished
				WAIT_POOL: begin
					if (pool_done) begin
						state <= FETCH;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// job fields, stable until the next decode
	always_ff @(posedge clk) begin
		if (state == DECODE && instr.opcode == layer_isa_pkg::OP_POOL) begin
			job.side     <= instr.side;
			job.channels <= instr.channels;
			job.rd_base  <= instr.rd_base;
			job.wr_base  <= instr.wr_base;
		end
	end

endmodule

`default_nettype wire

// ==== source/layer_isa_pkg.sv ====
`default_nettype none

// descriptor format and the job handed to the pooler
package layer_isa_pkg;

	// program memory word
	localparam int INSTR_W = 48;

	// any value other than OP_POOL ends the program
	typedef enum logic [3:0] {
		OP_HALT = 4'd0,
		OP_POOL = 4'd1
	} opcode_t;

	// square map side and channel count
	typedef logic [7:0] side_t;
	typedef logic [3:0] chan_t;

	////////////////////
	// descriptor, msb first
	typedef struct packed {
		opcode_t               opcode;
		side_t                 side;
		chan_t                 channels;
		engine_cfg_pkg::addr_t rd_base;
		engine_cfg_pkg::addr_t wr_base;
		logic [11:0]           spare;
	} layer_instr_t;

	// decoder to pooler, held from launch to pool_done
	typedef struct packed {
		side_t                 side;
		chan_t                 channels;
		engine_cfg_pkg::addr_t rd_base;
		engine_cfg_pkg::addr_t wr_base;
	} pool_job_t;

endpackage

`default_nettype wire

// ==== source/max_pooler.sv ====
`default_nettype none

module max_pooler (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      launch,
	input  layer_isa_pkg::pool_job_t  job,
	input  engine_cfg_pkg::pixel_t    map_rdata,
	output engine_cfg_pkg::sram_req_t map_req,
	output engine_cfg_pkg::sram_req_t res_req,
	output logic                      pool_done
);

	typedef enum logic [2:0] {
		IDLE,
		SETUP,
		READ,
		FOLD,
		WRITE
	} state_t;

	state_t                 state;
	logic [1:0]             tap;
	layer_isa_pkg::side_t   col;
	layer_isa_pkg::side_t   row;
	layer_isa_pkg::chan_t   chan;
	engine_cfg_pkg::addr_t  chan_base;
	engine_cfg_pkg::addr_t  row_base;
	engine_cfg_pkg::addr_t  wr_ptr;
	engine_cfg_pkg::pixel_t max_q;

	layer_isa_pkg::side_t  half;
	layer_isa_pkg::side_t  half_m1;
	engine_cfg_pkg::addr_t side_a;
	engine_cfg_pkg::addr_t row_step;
	engine_cfg_pkg::addr_t chan_step;
	engine_cfg_pkg::addr_t rd_addr;
	logic                  last_col;
	logic                  last_row;
	logic                  last_chan;
	logic                  empty;

	////////////////////
	// grid geometry
	// odd side drops last row and column
	assign half      = job.side >> 1;
	assign half_m1   = half - 8'd1;
	assign side_a    = engine_cfg_pkg::addr_t'(job.side);
	assign row_step  = side_a << 1;
	assign chan_step = side_a * side_a;
	assign last_col  = (col == half_m1);
	assign last_row  = (row == half_m1);
	assign last_chan = (chan == job.channels - 4'd1);
	assign empty     = (job.channels == '0) || (half == '0);

	// tap order (0,0) (0,1) (1,0) (1,1) inside the window
	assign rd_addr = row_base + (engine_cfg_pkg::addr_t'(col) << 1)
		+ (tap[1] ? side_a : '0) + engine_cfg_pkg::addr_t'(tap[0]);

	// reads during READ, one write per output pixel
	always_comb begin
		map_req       = '0;
		map_req.en    = (state == READ);
		map_req.addr  = rd_addr;
		res_req.en    = (state == WRITE);
		res_req.we    = (state == WRITE);
		res_req.addr  = wr_ptr;
		res_req.wdata = max_q;
	end

	////////////////////
	// control fsm
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= IDLE;
			tap       <= '0;
			col       <= '0;
			row       <= '0;
			chan      <= '0;
			pool_done <= 1'b0;
		end else begin
			pool_done <= 1'b0;
			case (state)
				IDLE: if (launch) state <= SETUP;
				SETUP: begin
					tap  <= '0;
					col  <= '0;
					row  <= '0;
					chan <= '0;
					// nothing to write, finish at once
					state     <= empty ? IDLE : READ;
					pool_done <= empty;
				end
				// tap wraps back to 0 after the fourth read
				READ: begin
					tap <= tap + 2'd1;
					if (tap == 2'd3) state <= FOLD;
				end
				FOLD: state <= WRITE;
				WRITE: begin
					state <= READ;
					col   <= col + 8'd1;
					if (last_col) begin
						col <= '0;
						row <= row + 8'd1;
						if (last_row) begin
							row  <= '0;
							chan <= chan + 4'd1;
							if (last_chan) begin
								pool_done <= 1'b1;
								state     <= IDLE;
							end
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	////////////////////
	// address pointers and running max
	always_ff @(posedge clk) begin
		case (state)
			SETUP: begin
				chan_base <= job.rd_base;
				row_base  <= job.rd_base;
				wr_ptr    <= job.wr_base;
			end
			// data of the previous tap arrives here
			READ: begin
				if (tap == 2'd0) max_q <= '0;
				else if (map_rdata > max_q) max_q <= map_rdata;
			end
			// last tap of the window
			FOLD: if (map_rdata > max_q) max_q <= map_rdata;
			WRITE: begin
				// output regions of all channels are contiguous
				wr_ptr <= wr_ptr + engine_cfg_pkg::addr_t'(1);
				if (last_col && !last_row) begin
					row_base <= row_base + row_step;
				end else if (last_col) begin
					chan_base <= chan_base + chan_step;
					row_base  <= chan_base + chan_step;
				end
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/pool_engine_top.sv ====
`default_nettype none

module pool_engine_top #(
	parameter int PROG_DEPTH = 64,
	parameter int MAP_DEPTH  = 1024
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        start,
	input  engine_cfg_pkg::sram_req_t   prog_wr,
	input  layer_isa_pkg::layer_instr_t prog_wdata,
	input  engine_cfg_pkg::sram_req_t   map_wr,
	input  engine_cfg_pkg::sram_req_t   res_rd,
	output engine_cfg_pkg::pixel_t      res_rdata,
	output logic                        busy,
	output logic                        done
);

	// decoder side
	layer_isa_pkg::layer_instr_t instr;
	engine_cfg_pkg::sram_req_t   prog_req;
	layer_isa_pkg::pool_job_t    job;
	logic                        launch;
	logic                        pool_done;

	// pooler side
	engine_cfg_pkg::sram_req_t   map_req;
	engine_cfg_pkg::pixel_t      map_rdata;
	engine_cfg_pkg::sram_req_t   res_req;

	////////////////////
	// descriptor fetch and sequencing
	layer_decoder u_layer_decoder (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.instr     (instr),
		.prog_req  (prog_req),
		.job       (job),
		.launch    (launch),
		.pool_done (pool_done),
		.busy      (busy),
		.done      (done)
	);

	max_pooler u_max_pooler (
		.clk       (clk),
		.rst_n     (rst_n),
		.launch    (launch),
		.job       (job),
		.map_rdata (map_rdata),
		.map_req   (map_req),
		.res_req   (res_req),
		.pool_done (pool_done)
	);

	////////////////////
	// memories, engine port first
	// program memory, decoder only reads
	shared_sram #(.DEPTH(PROG_DEPTH), .WIDTH(layer_isa_pkg::INSTR_W)) u_prog_mem (
		.clk        (clk),
		.eng_req    (prog_req),
		.eng_wdata  ('0),
		.host_req   (prog_wr),
		.host_wdata (prog_wdata),
		.rdata      (instr)
	);

	// input feature maps
	shared_sram #(.DEPTH(MAP_DEPTH), .WIDTH(engine_cfg_pkg::DATA_W)) u_map_mem (
		.clk        (clk),
		.eng_req    (map_req),
		.eng_wdata  (map_req.wdata),
		.host_req   (map_wr),
		.host_wdata (map_wr.wdata),
		.rdata      (map_rdata)
	);

	// pooled results, host reads back here
	shared_sram #(.DEPTH(MAP_DEPTH), .WIDTH(engine_cfg_pkg::DATA_W)) u_res_mem (
		.clk        (clk),
		.eng_req    (res_req),
		.eng_wdata  (res_req.wdata),
		.host_req   (res_rd),
		.host_wdata (res_rd.wdata),
		.rdata      (res_rdata)
	);

endmodule

`default_nettype wire

// ==== source/shared_sram.sv ====
`default_nettype none

module shared_sram #(
	parameter int DEPTH = 1024,
	parameter int WIDTH = 16
) (
	input  logic                      clk,
	input  engine_cfg_pkg::sram_req_t eng_req,
	input  logic [WIDTH-1:0]          eng_wdata,
	input  engine_cfg_pkg::sram_req_t host_req,
	input  logic [WIDTH-1:0]          host_wdata,
	output logic [WIDTH-1:0]          rdata
);

	// index bits actually used by the array
	localparam int AW = $clog2(DEPTH);

	engine_cfg_pkg::sram_req_t sel_req;
	logic [WIDTH-1:0]          sel_wdata;
	logic [WIDTH-1:0]          mem [DEPTH];

	// engine wins whenever it asks
	// a host access in the same cycle is dropped
	always_comb begin
		if (eng_req.en) begin
			sel_req   = eng_req;
			sel_wdata = eng_wdata;
		end else begin
			sel_req   = host_req;
			sel_wdata = host_wdata;
		end
	end

	// single port, read data registered
	always_ff @(posedge clk) begin
		if (sel_req.en) begin
			if (sel_req.we) begin
				mem[sel_req.addr[AW-1:0]] <= sel_wdata;
			end else begin
				rdata <= mem[sel_req.addr[AW-1:0]];
			end
		end
	end

endmodule

`default_nettype wire

// ==== test/pool_engine_props.sv ====
`default_nettype none

module pool_engine_props (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic busy,
	input logic done
);

	timeunit 1ns;
	timeprecision 100ps;

	// read by the testbench at the end of the run
	int fail_count = 0;

	// done is a single-cycle pulse
	done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
		else begin fail_count++; $error("done held longer than one cycle"); end

	// done arrives as busy drops, so busy was high the cycle before
	done_in_run: assert property (@(posedge clk) disable iff (!rst_n) done |-> $past(busy))
		else begin fail_count++; $error("done without a preceding busy cycle"); end

	// start from idle
	busy_after_start: assert property (
		@(posedge clk) disable iff (!rst_n) (start && !busy) |=> busy)
		else begin fail_count++; $error("busy did not rise after start"); end

	// quiet in reset
	quiet_in_reset: assert property (@(posedge clk) !rst_n |-> (!busy && !done))
		else begin fail_count++; $error("busy or done high during reset"); end

endmodule

bind pool_engine_top pool_engine_props u_props (
	.clk   (clk),
	.rst_n (rst_n),
	.start (start),
	.busy  (busy),
	.done  (done)
);

`default_nettype wire

// ==== test/tb_pool_engine.sv ====
`default_nettype none

module tb_pool_engine;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int          TIMEOUT_CYCLES = 5000;
	localparam int          MAP_WORDS      = 1024;
	localparam int unsigned SEED           = 32'h5d5f9192;

	logic                        clk;
	logic                        rst_n;
	logic                        start;
	engine_cfg_pkg::sram_req_t   prog_wr;
	layer_isa_pkg::layer_instr_t prog_wdata;
	engine_cfg_pkg::sram_req_t   map_wr;
	engine_cfg_pkg::sram_req_t   res_rd;
	engine_cfg_pkg::pixel_t      res_rdata;
	logic                        busy;
	logic                        done;

	// copy of everything written to the input map memory
	engine_cfg_pkg::pixel_t map_img [MAP_WORDS];

	int checks     = 0;
	int errors     = 0;
	int done_count = 0;

	pool_engine_top i_pool_engine_top (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.prog_wr    (prog_wr),
		.prog_wdata (prog_wdata),
		.map_wr     (map_wr),
		.res_rd     (res_rd),
		.res_rdata  (res_rdata),
		.busy       (busy),
		.done       (done)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// every done pulse, sampled mid-cycle
	always @(negedge clk) begin
		if (done === 1'b1) done_count++;
	end

	////////////////////
	// compare tasks
	task automatic check_pixel(input string name, input engine_cfg_pkg::pixel_t got,
		input engine_cfg_pkg::pixel_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	////////////////////
	// host port
	task automatic write_instr(input int addr, input layer_isa_pkg::layer_instr_t word);
		engine_cfg_pkg::sram_req_t req;
		req      = '0;
		req.en   = 1'b1;
		req.we   = 1'b1;
		req.addr = engine_cfg_pkg::addr_t'(addr);
		@(posedge clk);
		prog_wr    <= req;
		prog_wdata <= word;
		@(posedge clk);
		prog_wr <= '0;
	endtask

	task automatic write_map(input int addr, input engine_cfg_pkg::pixel_t value);
		engine_cfg_pkg::sram_req_t req;
		req       = '0;
		req.en    = 1'b1;
		req.we    = 1'b1;
		req.addr  = engine_cfg_pkg::addr_t'(addr);
		req.wdata = value;
		map_img[engine_cfg_pkg::addr_t'(addr)] = value;
		@(posedge clk);
		map_wr <= req;
		@(posedge clk);
		map_wr <= '0;
	endtask

	// data registered on the edge after the request
	task automatic read_result(input int addr, output engine_cfg_pkg::pixel_t value);
		engine_cfg_pkg::sram_req_t req;
		req      = '0;
		req.en   = 1'b1;
		req.addr = engine_cfg_pkg::addr_t'(addr);
		@(posedge clk);
		res_rd <= req;
		@(posedge clk);
		res_rd <= '0;
		@(negedge clk);
		value = res_rdata;
	endtask

	task automatic fill_random(input int base, input int count);
		for (int i = 0; i < count; i++) begin
			write_map(base + i, engine_cfg_pkg::pixel_t'($urandom));
		end
	endtask

	////////////////////
	// descriptors and reference model
	function automatic layer_isa_pkg::layer_instr_t pool_instr(input int side, input int chans,
		input int rd_base, input int wr_base);
		layer_isa_pkg::layer_instr_t word;
		word          = '0;
		word.opcode   = layer_isa_pkg::OP_POOL;
		word.side     = layer_isa_pkg::side_t'(side);
		word.channels = layer_isa_pkg::chan_t'(chans);
		word.rd_base  = engine_cfg_pkg::addr_t'(rd_base);
		word.wr_base  = engine_cfg_pkg::addr_t'(wr_base);
		return word;
	endfunction

	function automatic layer_isa_pkg::layer_instr_t halt_instr();
		layer_isa_pkg::layer_instr_t word;
		word        = '0;
		word.opcode = layer_isa_pkg::OP_HALT;
		return word;
	endfunction

	// unsigned max over the 2x2 window of output (r,c) in channel chan
	function automatic engine_cfg_pkg::pixel_t pool_max(input int rd_base, input int side,
		input int chan, input int r, input int c);
		engine_cfg_pkg::pixel_t best;
		engine_cfg_pkg::pixel_t v;
		int                     base;
		best = '0;
		base = rd_base + chan * side * side + 2 * r * side + 2 * c;
		for (int dr = 0; dr < 2; dr++) begin
			for (int dc = 0; dc < 2; dc++) begin
				v = map_img[engine_cfg_pkg::addr_t'(base + dr * side + dc)];
				if (v > best) best = v;
			end
		end
		return best;
	endfunction

	// outputs of all channels packed from wr_base
	task automatic check_job(input int side, input int chans, input int rd_base,
		input int wr_base);
		engine_cfg_pkg::pixel_t got;
		int                     half;
		int                     addr;
		half = side / 2;
		for (int k = 0; k < chans; k++) begin
			for (int r = 0; r < half; r++) begin
				for (int c = 0; c < half; c++) begin
					addr = wr_base + k * half * half + r * half + c;
					read_result(addr, got);
					check_pixel($sformatf("res[%0d]", addr), got,
						pool_max(rd_base, side, k, r, c));
				end
			end
		end
	endtask

	////////////////////
	// run control
	task automatic finish_run();
		errors += i_pool_engine_top.u_props.fail_count;
		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
			i_pool_engine_top.u_props.fail_count);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	endtask

	// start the program, optionally poke start again mid-run
	task automatic run_program(input bit extra_start);
		int waited;
		int dones_before;
		dones_before = done_count;
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		@(negedge clk);
		check_flag("busy", busy, 1'b1);
		if (extra_start) begin
			@(posedge clk);
			start <= 1'b1;
			@(posedge clk);
			start <= 1'b0;
		end
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (done !== 1'b1 && waited < TIMEOUT_CYCLES);
		if (done !== 1'b1) begin
			errors++;
			$display("timeout: no done within %0d cycles of start", TIMEOUT_CYCLES);
			finish_run();
		end else begin
			// busy falls together with done
			check_flag("busy", busy, 1'b0);
			// idle long enough for a stray done to show up
			repeat (20) @(posedge clk);
			check_count("done pulses", done_count - dones_before, 1);
		end
	endtask

	////////////////////
	// directed tests
	task automatic test_reset_state();
		@(negedge clk);
		check_flag("busy", busy, 1'b0);
		check_flag("done", done, 1'b0);
	endtask

	// top nibbles spread over 0..f to catch a signed compare
	task automatic test_known_values();
		for (int i = 0; i < 16; i++) begin
			write_map(i, engine_cfg_pkg::pixel_t'((((i * 11) % 16) << 12) + i));
		end
		write_instr(0, pool_instr(4, 1, 0, 0));
		write_instr(1, halt_instr());
		run_program(1'b0);
		check_job(4, 1, 0, 0);
	endtask

	// previous results must survive an empty program
	// halt word carries pool fields aimed at results 0..3 from fresh data
	task automatic test_halt_only();
		layer_isa_pkg::layer_instr_t word;
		fill_random(16, 16);
		word        = pool_instr(4, 1, 16, 0);
		word.opcode = layer_isa_pkg::OP_HALT;
		write_instr(0, word);
		run_program(1'b0);
		check_job(4, 1, 0, 0);
	endtask

	task automatic test_random_channels();
		fill_random(64, 192);
		write_instr(0, pool_instr(8, 3, 64, 100));
		write_instr(1, halt_instr());
		run_program(1'b0);
		check_job(8, 3, 64, 100);
	endtask

	task automatic test_two_layers();
		fill_random(300, 32);
		fill_random(400, 36);
		write_instr(0, pool_instr(4, 2, 300, 200));
		write_instr(1, pool_instr(6, 1, 400, 220));
		write_instr(2, halt_instr());
		run_program(1'b0);
		check_job(4, 2, 300, 200);
		check_job(6, 1, 400, 220);
	endtask

	// side 5 pools the top-left 4x4, word 108 follows the 8 outputs
	// and still holds output (2,0) of channel 0 of the 8x8 job
	task automatic test_odd_side();
		engine_cfg_pkg::pixel_t after;
		fill_random(500, 50);
		write_instr(0, pool_instr(5, 2, 500, 100));
		write_instr(1, halt_instr());
		run_program(1'b0);
		check_job(5, 2, 500, 100);
		read_result(108, after);
		check_pixel("res[108]", after, pool_max(64, 8, 0, 2, 0));
	endtask

	task automatic test_start_while_busy();
		fill_random(600, 64);
		write_instr(0, pool_instr(8, 1, 600, 300));
		write_instr(1, halt_instr());
		run_program(1'b1);
		check_job(8, 1, 600, 300);
	endtask

	initial begin
		void'($urandom(SEED));
		rst_n      <= 1'b0;
		start      <= 1'b0;
		prog_wr    <= '0;
		prog_wdata <= '0;
		map_wr     <= '0;
		res_rd     <= '0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		test_reset_state();
		test_known_values();
		test_halt_only();
		test_random_channels();
		test_two_layers();
		test_odd_side();
		test_start_while_busy();
		finish_run();
	end

endmodule

`default_nettype wire
